/* build.f */
icache_pkg.sv
icache_req_buf.sv
icache_lru.sv
icache_tagv.sv
icache_data.sv
icache_ctrl_fsm.sv
icache_top.sv
tb_icache_mem.sv
tb_icache.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_icache \
    --Mdir obj_dir -o sim_icache
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_icache > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

/* tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;

    localparam int max_cycles = 20000;  // about 4x the random mix length

    logic        clk;
    logic        rstn;
    logic        req_valid;
    logic [31:0] req_addr;
    logic        req_opflag;
    logic [31:0] req_opcode;
    logic        req_uncached;
    logic        pipe_stall;
    logic        pipe_flush;
    logic        stall;
    logic        rdata_valid;
    logic [31:0] rdata;
    logic        done_op;
    logic        ack_op;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_data_ok;
    logic [127:0] mem_line;

    // expectations, updated on falling edges
    logic        exp_open;
    logic        exp_hit;
    logic [31:0] exp_word;
    logic        op_open;
    logic        ack_exp;
    logic        mem_allowed;
    logic        stall_exp;
    int          lat_cnt;
    int          errors;
    int          cycles = 0;
    int          fetch_count;
    int          rv_count = 0;
    int          test_start;
    logic [31:0] rnd;

    // reference model of the tag side
    logic [23:0] m_tag [2][16];
    logic        m_valid [2][16];
    logic        m_lru [16];

    assign mem_allowed = exp_open && !exp_hit;
    // a miss holds stall from lookup until its result
    assign stall_exp   = exp_open && !exp_hit && lat_cnt > 0 && !rdata_valid;

    icache_top #(.index_width(4), .offset_width(2)) dut0 (
        .clk(clk), .rstn(rstn), .req_valid(req_valid), .req_addr(req_addr),
        .req_opflag(req_opflag), .req_opcode(req_opcode), .req_uncached(req_uncached),
        .pipe_stall(pipe_stall), .pipe_flush(pipe_flush), .stall(stall),
        .rdata_valid(rdata_valid), .rdata(rdata), .done_op(done_op), .ack_op(ack_op),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_data_ok(mem_data_ok),
        .mem_line(mem_line)
    );

    tb_icache_mem #(.line_words(4)) mem0 (
        .clk(clk), .rstn(rstn), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_data_ok(mem_data_ok), .mem_line(mem_line)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rstn && rdata_valid) rv_count <= rv_count + 1;
        if (cycles >= max_cycles) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!rstn) rdata_valid |-> exp_open)
        else begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t rdata_valid exp 0 got 1", $time);
        end

    assert property (@(posedge clk) disable iff (!rstn) rdata_valid |-> rdata == exp_word)
        else begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t rdata exp %h got %h", $time, exp_word,
                     $sampled(rdata));
        end

    assert property (@(posedge clk) disable iff (!rstn) mem_req |-> mem_allowed)
        else begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t mem_req exp 0 got 1", $time);
        end

    assert property (@(posedge clk) disable iff (!rstn)
                     rdata_valid && exp_hit |-> lat_cnt == 1)
        else begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t hit latency exp 1 got %0d", $time,
                     $sampled(lat_cnt));
        end

    assert property (@(posedge clk) disable iff (!rstn) done_op |-> op_open)
        else begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t done_op exp 0 got 1", $time);
        end

    assert property (@(posedge clk) disable iff (!rstn) ack_op == ack_exp)
        else begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t ack_op exp %b got %b", $time,
                     $sampled(ack_exp), $sampled(ack_op));
        end

    assert property (@(posedge clk) disable iff (!rstn) stall == stall_exp)
        else begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t stall exp %b got %b", $time,
                     $sampled(stall_exp), $sampled(stall));
        end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory content rule: each word is the xorshift of its address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return xorshift32({a[31:2], 2'b00});
    endfunction

    task automatic model_probe(input logic [31:0] a, output logic h, output logic w);
        logic [3:0] idx;
        idx = a[7:4];
        h = 1'b0;
        w = 1'b0;
        if (m_valid[0][idx] && m_tag[0][idx] == a[31:8]) begin
            h = 1'b1;
        end else if (m_valid[1][idx] && m_tag[1][idx] == a[31:8]) begin
            h = 1'b1;
            w = 1'b1;
        end
    endtask

    // starts and ends on a falling edge
    task automatic fetch(input logic [31:0] a, input logic unc);
        logic       h;
        logic       w;
        logic       v;
        logic       saw_mem;
        logic [3:0] idx;
        int         rv_start;
        idx = a[7:4];
        model_probe(a, h, w);
        req_valid    = 1'b1;
        req_addr     = a;
        req_uncached = unc;
        req_opflag   = 1'b0;
        exp_hit      = h && !unc;
        exp_word     = mem_word(a);
        exp_open     = 1'b1;
        lat_cnt      = 0;
        saw_mem      = 1'b0;
        rv_start     = rv_count;
        fetch_count++;
        @(posedge clk);
        do begin
            @(negedge clk);
            req_valid = 1'b0;
            lat_cnt++;
            if (mem_req) saw_mem = 1'b1;
        end while (rv_count == rv_start);  // result counted at the rising edge
        if (!exp_hit && !saw_mem) begin
            errors++;
            $display("predicted miss at %h did not raise mem_req", a);
        end
        if (unc) begin
            if (h) m_valid[w][idx] = 1'b0;  // cached copy dropped
        end else if (h) begin
            m_lru[idx] = !w;
        end else begin
            v = m_lru[idx];
            m_tag[v][idx]   = a[31:8];
            m_valid[v][idx] = 1'b1;
            m_lru[idx]      = !v;
        end
        exp_open = 1'b0;
    endtask

    task automatic maint(input logic [31:0] a, input logic [31:0] opc);
        logic       h;
        logic       w;
        logic [3:0] idx;
        idx = a[7:4];
        req_valid  = 1'b1;
        req_opflag = 1'b1;
        req_addr   = a;
        req_opcode = opc;
        op_open    = 1'b1;
        ack_exp    = 1'b1;  // acceptance cycle
        @(posedge clk);
        @(negedge clk);
        req_valid  = 1'b0;
        req_opflag = 1'b0;
        ack_exp    = 1'b0;
        assert (done_op) else begin
            errors++;
            $display("CHECK FAILED t=%0t done_op exp 1 got 0", $time);
        end
        if (opc[31]) begin
            for (int i = 0; i < 16; i++) begin
                m_valid[0][i] = 1'b0;
                m_valid[1][i] = 1'b0;
            end
        end else begin
            case (opc[4:3])
                2'd0: begin
                    m_tag[a[0]][idx]   = '0;
                    m_valid[a[0]][idx] = 1'b0;
                end
                2'd1: m_valid[a[0]][idx] = 1'b0;
                2'd2: begin
                    model_probe(a, h, w);
                    if (h) m_valid[w][idx] = 1'b0;
                end
                default: ;
            endcase
        end
        @(negedge clk);
        op_open = 1'b0;
    endtask

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rstn = 1'b0;
        req_valid = 1'b0;
        req_addr = '0;
        req_opflag = 1'b0;
        req_opcode = '0;
        req_uncached = 1'b0;
        pipe_stall = 1'b0;
        pipe_flush = 1'b0;
        exp_open = 1'b0;
        exp_hit = 1'b0;
        exp_word = '0;
        op_open = 1'b0;
        ack_exp = 1'b0;
        lat_cnt = 0;
        errors = 0;
        fetch_count = 0;
        test_start = 0;
        rnd = 32'd94497;
        for (int i = 0; i < 16; i++) begin
            m_valid[0][i] = 1'b0;
            m_valid[1][i] = 1'b0;
            m_tag[0][i] = '0;
            m_tag[1][i] = '0;
            m_lru[i] = 1'b0;
        end
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        fetch(32'h0000_1234, 1'b0);
        fetch(32'h0000_1238, 1'b0);  // same line
        report_test("miss then hit");

        fetch(32'h0000_0150, 1'b0);
        fetch(32'h0000_0250, 1'b0);
        fetch(32'h0000_0154, 1'b0);
        fetch(32'h0000_0358, 1'b0);  // evicts 0x250
        fetch(32'h0000_015c, 1'b0);
        fetch(32'h0000_0250, 1'b0);
        report_test("lru replacement");

        fetch(32'h0000_4460, 1'b0);
        fetch(32'h0000_4464, 1'b1);
        fetch(32'h0000_4468, 1'b0);
        report_test("uncached fetch");

        maint(32'h0, 32'h8000_0000);  // invalidate-all
        fetch(32'h0000_1234, 1'b0);
        fetch(32'h0000_0570, 1'b0);
        fetch(32'h0000_0670, 1'b0);
        maint(32'h0000_0070, {27'd0, 2'd0, 3'd0});
        maint(32'h0000_0071, {27'd0, 2'd1, 3'd0});
        fetch(32'h0000_0570, 1'b0);
        fetch(32'h0000_0670, 1'b0);
        maint(32'h0000_1230, {27'd0, 2'd2, 3'd0});
        fetch(32'h0000_1234, 1'b0);
        report_test("maintenance");

        // a hit flushed in lookup reports nothing
        req_valid = 1'b1;
        req_addr = 32'h0000_1234;
        @(posedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        pipe_flush = 1'b1;
        repeat (2) @(negedge clk);
        pipe_flush = 1'b0;
        @(negedge clk);
        pipe_stall = 1'b1;
        req_valid = 1'b1;
        req_addr = 32'h0000_7780;
        repeat (6) @(negedge clk);
        req_valid = 1'b0;
        pipe_stall = 1'b0;
        @(negedge clk);
        report_test("flush and stall");

        for (int n = 0; n < 400; n++) begin
            rnd = xorshift32(rnd);
            if (rnd[18:16] == 3'd0) begin
                maint({22'd0, rnd[13:12], 2'b00, rnd[9:8], 3'd0, rnd[0]},
                      (rnd[4:3] == 2'd3) ? 32'h8000_0000 : {27'd0, rnd[4:3], 3'd0});
            end else begin
                fetch({22'd0, rnd[13:12], 2'b00, rnd[9:8], rnd[11:10], 2'b00},
                      rnd[22:20] == 3'd0);
            end
        end
        report_test("random mix");

        if (rv_count != fetch_count) begin
            errors++;
            $display("saw %0d results for %0d fetches", rv_count, fetch_count);
        end
        $display("fetches %0d results %0d errors %0d", fetch_count, rv_count, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb_icache_mem.sv */
`timescale 1ns/1ps

module tb_icache_mem #(
    parameter int line_words = 4
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    mem_req,
    input  logic [31:0]             mem_addr,
    output logic                    mem_data_ok,
    output logic [32*line_words-1:0] mem_line
);

    logic [31:0] rnd;
    logic        busy;
    logic [2:0]  wait_cnt;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory side changes on the falling edge, like the rest of the stimulus
    always @(negedge clk) begin
        if (!rstn) begin
            busy        <= 1'b0;
            mem_data_ok <= 1'b0;
            wait_cnt    <= 3'd0;
            rnd         <= 32'd94497;
            mem_line    <= '0;
        end else if (mem_data_ok) begin
            mem_data_ok <= 1'b0;  // one cycle pulse
            busy        <= 1'b0;
        end else if (busy) begin
            if (wait_cnt == 3'd0) begin
                mem_data_ok <= 1'b1;
                for (int i = 0; i < line_words; i++) begin
                    mem_line[i*32 +: 32] <= xorshift32(mem_addr + 32'(4 * i));
                end
            end else begin
                wait_cnt <= wait_cnt - 3'd1;
            end
        end else if (mem_req) begin
            busy     <= 1'b1;
            rnd      <= xorshift32(rnd);
            wait_cnt <= rnd[2:0];  // roughly 2 to 9 cycles overall
        end
    end

endmodule

/* icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
    parameter int  index_width  = 4,
    parameter int  offset_width = 2,
    localparam int line_w       = icache_pkg::word_w * (2 ** offset_width)
) (
    input  logic                          clk,
    input  logic                          rstn,
    // pipeline side
    input  logic                          req_valid,
    input  logic [icache_pkg::addr_w-1:0] req_addr,
    input  logic                          req_opflag,
    input  logic [31:0]                   req_opcode,
    input  logic                          req_uncached,
    input  logic                          pipe_stall,
    input  logic                          pipe_flush,
    output logic                          stall,
    output logic                          rdata_valid,
    output logic [icache_pkg::word_w-1:0] rdata,
    output logic                          done_op,
    output logic                          ack_op,
    // memory side
    output logic                          mem_req,
    output logic [icache_pkg::addr_w-1:0] mem_addr,
    input  logic                          mem_data_ok,
    input  logic [line_w-1:0]             mem_line
);
    import icache_pkg::*;

    logic [addr_w-1:0] buf_addr;
    logic [31:0]       buf_opcode;
    logic              buf_opflag;
    logic              buf_uncached;
    logic              buf_we;
    logic [1:0]        hit;
    logic              victim_way;
    logic              use0;
    logic              use1;
    logic [1:0]        data_we;  // also the tag write strobe
    logic [1:0]        tagv_inv;
    logic              tagv_ibar;
    logic              tagv_init_en;
    logic              tagv_init_way;
    logic              sel_way;
    logic              sel_return;

    // line aligned fetch
    assign mem_addr = {buf_addr[addr_w-1:offset_width+2], {(offset_width + 2){1'b0}}};

    icache_req_buf #(
        .index_width (index_width),
        .offset_width(offset_width)
    ) u_req_buf (
        .clk        (clk),
        .rstn       (rstn),
        .we         (buf_we),
        .in_addr    (req_addr),
        .in_opcode  (req_opcode),
        .in_opflag  (req_opflag),
        .in_uncached(req_uncached),
        .addr       (buf_addr),
        .opcode     (buf_opcode),
        .opflag     (buf_opflag),
        .uncached   (buf_uncached)
    );

    icache_lru #(
        .index_width(index_width)
    ) u_lru (
        .clk       (clk),
        .rstn      (rstn),
        .index     (buf_addr[offset_width+2 +: index_width]),
        .use0      (use0),
        .use1      (use1),
        .victim_way(victim_way)
    );

    icache_tagv #(
        .index_width (index_width),
        .offset_width(offset_width)
    ) u_tagv (
        .clk     (clk),
        .rstn    (rstn),
        .addr    (buf_addr),
        .tag_we  (data_we),
        .inv     (tagv_inv),
        .ibar    (tagv_ibar),
        .init_en (tagv_init_en),
        .init_way(tagv_init_way),
        .hit     (hit)
    );

    icache_data #(
        .index_width (index_width),
        .offset_width(offset_width)
    ) u_data (
        .clk       (clk),
        .addr      (buf_addr),
        .we        (data_we),
        .mem_line  (mem_line),
        .sel_way   (sel_way),
        .sel_return(sel_return),
        .word      (rdata)
    );

    icache_ctrl_fsm u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .req_valid    (req_valid),
        .req_opflag   (req_opflag),
        .pipe_stall   (pipe_stall),
        .pipe_flush   (pipe_flush),
        .mem_data_ok  (mem_data_ok),
        .buf_opflag   (buf_opflag),
        .buf_opcode   (buf_opcode),
        .buf_addr     (buf_addr),
        .buf_uncached (buf_uncached),
        .hit          (hit),
        .victim_way   (victim_way),
        .rdata_valid  (rdata_valid),
        .stall        (stall),
        .done_op      (done_op),
        .ack_op       (ack_op),
        .mem_req      (mem_req),
        .buf_we       (buf_we),
        .use0         (use0),
        .use1         (use1),
        .data_we      (data_we),
        .tagv_inv     (tagv_inv),
        .tagv_ibar    (tagv_ibar),
        .tagv_init_en (tagv_init_en),
        .tagv_init_way(tagv_init_way),
        .sel_way      (sel_way),
        .sel_return   (sel_return)
    );

endmodule

/* icache_ctrl_fsm.sv */
`timescale 1ns/1ps

module icache_ctrl_fsm (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          req_valid,
    input  logic                          req_opflag,
    input  logic                          pipe_stall,
    input  logic                          pipe_flush,
    input  logic                          mem_data_ok,
    input  logic                          buf_opflag,
    input  logic [31:0]                   buf_opcode,
    input  logic [icache_pkg::addr_w-1:0] buf_addr,
    input  logic                          buf_uncached,
    input  logic [1:0]                    hit,
    input  logic                          victim_way,
    output logic                          rdata_valid,
    output logic                          stall,
    output logic                          done_op,
    output logic                          ack_op,
    output logic                          mem_req,
    output logic                          buf_we,
    output logic                          use0,
    output logic                          use1,
    output logic [1:0]                    data_we,
    output logic [1:0]                    tagv_inv,
    output logic                          tagv_ibar,
    output logic                          tagv_init_en,
    output logic                          tagv_init_way,
    output logic                          sel_way,
    output logic                          sel_return
);
    import icache_pkg::*;

    state_t   state;
    state_t   next_state;
    state_t   req_state;  // target of an accepted request
    op_kind_t op_kind;
    logic     miss;
    logic     rstn_q;
    logic     hold_q;     // hit already reported, pipeline stalled
    logic     drop_q;     // flushed miss, refill without forwarding
    logic     valid_c;

    assign miss    = (hit == 2'b00) || buf_uncached;
    assign op_kind = op_kind_t'(buf_opcode[op_kind_hi:op_kind_lo]);

    always_ff @(posedge clk) begin
        rstn_q <= rstn;
    end

    // no result in the first cycle out of reset
    assign rdata_valid = valid_c && rstn_q;
    assign done_op     = (state == operation);
    assign ack_op      = (next_state == operation);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state  <= idle;
            hold_q <= 1'b0;
            drop_q <= 1'b0;
        end else begin
            state  <= next_state;
            hold_q <= (state == lookup) && !miss && pipe_stall && !pipe_flush;
            if (state == miss_wait && mem_data_ok) begin
                drop_q <= 1'b0;
            end else if (pipe_flush && (state == miss_wait || (state == lookup && miss))) begin
                drop_q <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        req_state = idle;
        if (req_valid && !pipe_stall) begin
            req_state = req_opflag ? operation : lookup;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: next_state = req_state;
            lookup: begin
                if (miss) begin
                    next_state = miss_wait;  // memory read always completes
                end else if (pipe_flush) begin
                    next_state = flush;
                end else if (pipe_stall) begin
                    next_state = lookup;
                end else begin
                    next_state = req_state;
                end
            end
            miss_wait: begin
                if (mem_data_ok) begin
                    next_state = pipe_flush ? flush : req_state;
                end
            end
            operation: next_state = pipe_flush ? flush : req_state;
            flush:     next_state = pipe_flush ? flush : req_state;
            default:   next_state = idle;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        valid_c       = 1'b0;
        stall         = 1'b1;
        mem_req       = 1'b0;
        buf_we        = 1'b0;
        use0          = 1'b0;
        use1          = 1'b0;
        data_we       = 2'b00;
        tagv_inv      = 2'b00;
        tagv_ibar     = 1'b0;
        tagv_init_en  = 1'b0;
        tagv_init_way = 1'b0;
        sel_way       = 1'b0;
        sel_return    = 1'b0;
        case (state)
            idle, flush: begin
                stall  = 1'b0;
                buf_we = 1'b1;
            end
            lookup: begin
                sel_way = !hit[0] && hit[1];
                if (miss) begin
                    mem_req = 1'b1;
                end else begin
                    stall   = 1'b0;
                    buf_we  = !pipe_stall;  // keep the address while held
                    valid_c = !pipe_flush && !hold_q;
                end
                if (!pipe_flush) begin
                    if (buf_uncached) begin
                        // uncached hit drops the cached copy
                        tagv_inv = hit[0] ? 2'b01 : {hit[1], 1'b0};
                    end else begin
                        use0 = hit[0];
                        use1 = !hit[0] && hit[1];
                    end
                end
            end
            miss_wait: begin
                mem_req = 1'b1;
                if (mem_data_ok) begin
                    stall      = 1'b0;
                    buf_we     = 1'b1;
                    sel_return = 1'b1;
                    valid_c    = !drop_q && !pipe_flush;
                    if (!buf_uncached) begin
                        data_we[victim_way] = 1'b1;
                        use0 = !victim_way;
                        use1 = victim_way;
                    end
                end
            end
            operation: begin
                stall  = 1'b0;
                buf_we = 1'b1;
                if (!pipe_flush && buf_opflag) begin
                    if (buf_opcode[op_ibar_bit]) begin
                        tagv_ibar = 1'b1;
                    end else begin
                        case (op_kind)
                            op_init: begin
                                tagv_init_en  = 1'b1;
                                tagv_init_way = buf_addr[0];  // way in addr bit 0
                            end
                            op_idx_inv: tagv_inv = buf_addr[0] ? 2'b10 : 2'b01;
                            op_hit_inv: tagv_inv = hit[0] ? 2'b01 : {hit[1], 1'b0};
                            default: ;
                        endcase
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

/* icache_data.sv */
`timescale 1ns/1ps

module icache_data #(
    parameter int  index_width  = 4,
    parameter int  offset_width = 2,
    localparam int line_w       = icache_pkg::word_w * (2 ** offset_width)
) (
    input  logic                          clk,
    input  logic [icache_pkg::addr_w-1:0] addr,
    input  logic [1:0]                    we,
    input  logic [line_w-1:0]             mem_line,
    input  logic                          sel_way,
    input  logic                          sel_return,
    output logic [icache_pkg::word_w-1:0] word
);
    import icache_pkg::*;

    localparam int sets = 2 ** index_width;

    logic [line_w-1:0]       line_q [2][sets];
    logic [line_w-1:0]       line_sel;
    logic [index_width-1:0]  index;
    logic [offset_width-1:0] offset;

    assign index  = addr[offset_width+2 +: index_width];
    assign offset = addr[2 +: offset_width];

    // refill writes the whole line
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (we[w]) begin
                line_q[w][index] <= mem_line;
            end
        end
    end

    // memory return bypasses the array on a miss
    assign line_sel = sel_return ? mem_line : line_q[sel_way][index];
    assign word     = line_sel[offset*word_w +: word_w];

endmodule

/* icache_tagv.sv */
`timescale 1ns/1ps

module icache_tagv #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [icache_pkg::addr_w-1:0] addr,
    input  logic [1:0]                    tag_we,
    input  logic [1:0]                    inv,
    input  logic                          ibar,
    input  logic                          init_en,
    input  logic                          init_way,
    output logic [1:0]                    hit
);
    import icache_pkg::*;

    localparam int tag_w = addr_w - index_width - offset_width - 2;
    localparam int sets  = 2 ** index_width;

    logic [tag_w-1:0]       tag_q [2][sets];
    logic [sets-1:0]        valid_q [2];
    logic [index_width-1:0] index;
    logic [tag_w-1:0]       tag;
    logic [1:0]             init_mask;  // way picked by init-by-index

    assign index     = addr[offset_width+2 +: index_width];
    assign tag       = addr[addr_w-1 -: tag_w];
    assign init_mask = {2{init_en}} & {init_way, ~init_way};

    ////////////////////////////////////////////////////////////////////////////
    // per way tag store and compare
    ////////////////////////////////////////////////////////////////////////////

    for (genvar w = 0; w < 2; w++) begin : g_way
        always_ff @(posedge clk) begin
            if (tag_we[w]) begin
                tag_q[w][index] <= tag;
            end else if (init_mask[w]) begin
                tag_q[w][index] <= '0;
            end
        end

        always_ff @(posedge clk) begin
            if (!rstn || ibar) begin
                valid_q[w] <= '0;  // invalidate-all
            end else if (tag_we[w]) begin
                valid_q[w][index] <= 1'b1;
            end else if (inv[w] || init_mask[w]) begin
                valid_q[w][index] <= 1'b0;
            end
        end

        assign hit[w] = valid_q[w][index] && (tag_q[w][index] == tag);
    end

endmodule

/* icache_lru.sv */
`timescale 1ns/1ps

module icache_lru #(
    parameter int index_width = 4
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_width-1:0] index,
    input  logic                   use0,
    input  logic                   use1,
    output logic                   victim_way
);

    // one bit per set, names the way to replace next
    logic [2**index_width-1:0] lru_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (use0) begin
            lru_q[index] <= 1'b1;  // way 0 just used
        end else if (use1) begin
            lru_q[index] <= 1'b0;
        end
    end

    assign victim_way = lru_q[index];

endmodule

/* icache_req_buf.sv */
`timescale 1ns/1ps

module icache_req_buf #(
    parameter int index_width  = 4,
    parameter int offset_width = 2
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          we,
    input  logic [icache_pkg::addr_w-1:0] in_addr,
    input  logic [31:0]                   in_opcode,
    input  logic                          in_opflag,
    input  logic                          in_uncached,
    output logic [icache_pkg::addr_w-1:0] addr,
    output logic [31:0]                   opcode,
    output logic                          opflag,
    output logic                          uncached
);
    import icache_pkg::*;

    localparam int tag_w = addr_w - index_width - offset_width - 2;

    logic [tag_w-1:0]        tag_q;
    logic [index_width-1:0]  index_q;
    logic [offset_width-1:0] offset_q;
    logic [1:0]              byte_q;  // way select of index ops

    always_ff @(posedge clk) begin
        if (we) begin
            tag_q    <= in_addr[addr_w-1 -: tag_w];
            index_q  <= in_addr[offset_width+2 +: index_width];
            offset_q <= in_addr[2 +: offset_width];
            byte_q   <= in_addr[1:0];
            opcode   <= in_opcode;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            opflag   <= 1'b0;
            uncached <= 1'b0;
        end else if (we) begin
            opflag   <= in_opflag;
            uncached <= in_uncached;
        end
    end

    assign addr = {tag_q, index_q, offset_q, byte_q};

endmodule

/* icache_pkg.sv */
package icache_pkg;

    localparam int addr_w = 32;
    localparam int word_w = 32;

    // main control states
    typedef enum logic [2:0] {
        idle      = 3'd0,
        lookup    = 3'd1,
        miss_wait = 3'd2,
        operation = 3'd3,
        flush     = 3'd4
    } state_t;

    ////////////////////////////////////////////////////////////////////////////
    // maintenance opcode fields
    ////////////////////////////////////////////////////////////////////////////

    localparam int op_ibar_bit = 31;  // invalidate-all
    localparam int op_kind_lo  = 3;
    localparam int op_kind_hi  = 4;

    typedef enum logic [1:0] {
        op_init    = 2'd0,  // tag and valid of one way
        op_idx_inv = 2'd1,  // valid of one way
        op_hit_inv = 2'd2   // valid of the hit way
    } op_kind_t;

endpackage
